// ==== ooo_core.f ====
+incdir+verif
design/isa_pkg.sv
design/core_pkg.sv
design/inst_decode.sv
design/rename_map.sv
design/rob.sv
design/fu_pipes.sv
design/retire_unit.sv
design/ooo_core.sv
verif/tb_ooo_core.sv

// ==== run.sh ====
#!/bin/sh
# build and run the ooo_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_ooo_core \
    -f ooo_core.f \
    -o sim_ooo_core

./obj_dir/sim_ooo_core > sim.log
cat sim.log

# the run passes only if the pass line made it to the log
grep -q -x "TEST RESULT: PASS" sim.log

// ==== verif/core_model.svh ====
//////////////////////////////
// core reference model
//////////////////////////////
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// accepted instructions, oldest at the front
isa_pkg::fetch_packet  exp_q[$];
// committed arch register to tag map
core_pkg::phys_reg_idx model_map[isa_pkg::NUM_ARCH_REGS];
int                    accepted_count;
int                    model_retired;
bit                    halt_accepted;
bit                    halt_retired;

task automatic model_reset();
    exp_q.delete();
    // identity map, same as the core after reset
    for (int r = 0; r < isa_pkg::NUM_ARCH_REGS; r++) begin
        model_map[r] = core_pkg::phys_reg_idx'(r);
    end
    accepted_count = 0;
    model_retired  = 0;
    halt_accepted  = 1'b0;
    halt_retired   = 1'b0;
endtask

task automatic model_accept(input isa_pkg::fetch_packet fp);
    exp_q.push_back(fp);
    accepted_count++;
    if (fp.inst.opcode == isa_pkg::OP_HALT) begin
        halt_accepted = 1'b1;
    end
endtask

// number of tags held by more than one arch register
function automatic int map_duplicates();
    logic [core_pkg::NUM_PHYS_REGS-1:0] seen;
    int                                 dups;
    seen = '0;
    dups = 0;
    for (int r = 0; r < isa_pkg::NUM_ARCH_REGS; r++) begin
        if (seen[model_map[r]]) begin
            dups++;
        end
        seen[model_map[r]] = 1'b1;
    end
    return dups;
endfunction

task automatic model_retire(input core_pkg::retire_packet rp);
    isa_pkg::fetch_packet exp_inst;
    logic                 exp_halt;
    int                   dups;
    assert (exp_q.size() > 0) else begin
        error_count++;
        $display("pc %0d retired with no accepted instruction outstanding", rp.pc);
    end
    if (exp_q.size() == 0) begin
        return;
    end
    exp_inst = exp_q.pop_front();
    exp_halt = (exp_inst.inst.opcode == isa_pkg::OP_HALT);
    model_retired++;
    assert (rp.pc == exp_inst.pc)
        else report_value("in_order_pc", int'(exp_inst.pc), int'(rp.pc));
    assert (rp.dest == exp_inst.inst.dest)
        else report_value("retire_dest", int'(exp_inst.inst.dest), int'(rp.dest));
    assert (rp.halt == exp_halt)
        else report_value("retire_halt", int'(exp_halt), int'(rp.halt));
    // halt carries no tags
    if (exp_halt) begin
        halt_retired = 1'b1;
        return;
    end
    assert (rp.t_old == model_map[rp.dest])
        else report_value("rename_t_old", int'(model_map[rp.dest]), int'(rp.t_old));
    // the new tag must not still belong to another register
    for (int r = 0; r < isa_pkg::NUM_ARCH_REGS; r++) begin
        if (r != int'(rp.dest)) begin
            assert (model_map[r] != rp.t) else begin
                error_count++;
                $display("tag %0d retired for r%0d is still mapped to r%0d", rp.t, rp.dest, r);
            end
        end
    end
    model_map[rp.dest] = rp.t;
    dups = map_duplicates();
    assert (dups == 0) else report_value("map_aliasing", 0, dups);
endtask

`endif

// ==== verif/tb_ooo_core.sv ====
//////////////////////////////
// ooo core testbench
//////////////////////////////
`timescale 1ns/10ps

module tb_ooo_core;

    localparam int N            = 2;
    localparam int DEPTH        = 16;
    localparam int MUL_LAT      = 3;
    localparam int CNT_W        = $clog2(N + 1);
    localparam int NUM_INSTS    = 2000;
    localparam int RESET_CYCLES = 4;
    // each instruction may wait out a whole multiply plus the retire path
    localparam int TIMEOUT_CYCLES = NUM_INSTS * (MUL_LAT + 4) + 100;

    logic                           clock;
    logic                           reset;
    isa_pkg::fetch_packet   [N-1:0] fetch;
    logic [CNT_W-1:0]               num_accept;
    core_pkg::retire_packet [N-1:0] retire;
    logic                           halted;
    logic [31:0]                    retired_count;

    int                   seed;
    int                   error_count;
    int                   cycle_count;
    int                   offered;
    isa_pkg::fetch_packet prog_q[$];

    task automatic report_value(input string test, input int expected, input int actual);
        error_count++;
        $display("** Error [%s] expected %0d, actual %0d", test, expected, actual);
    endtask

    `include "core_model.svh"

    ooo_core #(.N(N), .DEPTH(DEPTH), .MUL_LAT(MUL_LAT)) i_ooo_core (
        .clock         (clock),
        .reset         (reset),
        .fetch         (fetch),
        .num_accept    (num_accept),
        .retire        (retire),
        .halted        (halted),
        .retired_count (retired_count)
    );

    always #4 clock = ~clock;

    // run limit
    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout, halt not retired after %0d cycles", TIMEOUT_CYCLES);
            $display("errors: %0d, accepted: %0d, retired: %0d",
                     error_count, accepted_count, model_retired);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic int rand_below(input int limit);
        return int'(($random(seed) & 32'h7fff_ffff) % limit);
    endfunction

    // about 40% multiplies, the rest alu ops or unknown codes, halt at the end
    task automatic build_program();
        isa_pkg::fetch_packet fp;
        logic [2:0]           code;
        for (int k = 0; k < NUM_INSTS; k++) begin
            if (rand_below(100) < 40) begin
                code = isa_pkg::OP_MUL;
            end else begin
                // picks 0, 1, 2, 5, 6 or 7
                code = 3'(rand_below(6));
                if (code >= 3'd3) begin
                    code = code + 3'd2;
                end
            end
            if (k == NUM_INSTS - 1) begin
                code = isa_pkg::OP_HALT;
            end
            fp.valid       = 1'b1;
            fp.pc          = isa_pkg::pc_t'(k * 4);
            fp.inst.opcode = isa_pkg::opcode_t'(code);
            fp.inst.dest   = isa_pkg::arch_reg_idx'(rand_below(32));
            fp.inst.imm    = 8'(rand_below(256));
            prog_q.push_back(fp);
        end
    endtask

    // offer 0 to N slots from the queue head
    task automatic drive_fetch();
        offered = rand_below(N + 1);
        if (offered > prog_q.size()) begin
            offered = prog_q.size();
        end
        for (int i = 0; i < N; i++) begin
            if (i < offered) begin
                fetch[i] = prog_q[i];
            end else begin
                fetch[i] = '0;
            end
        end
    endtask

    task automatic check_retire_slots();
        bit gap;
        gap = 1'b0;
        for (int i = 0; i < N; i++) begin
            if (retire[i].valid) begin
                assert (!gap) else begin
                    error_count++;
                    $display("retire slot %0d valid after an empty slot", i);
                end
                assert (!halt_retired) else begin
                    error_count++;
                    $display("pc %0d retired after the halt", retire[i].pc);
                end
                model_retire(retire[i]);
            end else begin
                gap = 1'b1;
            end
        end
        assert (halted !== 1'b1 || halt_retired) else begin
            error_count++;
            $display("halted went high before the halt retired");
        end
    endtask

    task automatic check_accept();
        isa_pkg::fetch_packet fp;
        int                   acc;
        acc = int'(num_accept);
        assert (acc <= offered) else report_value("accept_limit", offered, acc);
        if (reset || halt_accepted) begin
            assert (acc == 0) else report_value("accept_idle", 0, acc);
        end else begin
            // the core takes these at the coming rising edge
            for (int i = 0; i < acc && i < offered; i++) begin
                fp = prog_q.pop_front();
                model_accept(fp);
            end
        end
    endtask

    // drive after the rising edge, sample at the falling edge
    task automatic run_cycle();
        @(posedge clock);
        #1;
        if (cycle_count >= RESET_CYCLES) begin
            reset = 1'b0;
        end
        drive_fetch();
        @(negedge clock);
        check_retire_slots();
        check_accept();
    endtask

    initial begin
        clock       = 1'b0;
        reset       = 1'b1;
        fetch       = '0;
        seed        = 23;
        error_count = 0;
        cycle_count = 0;
        offered     = 0;
        model_reset();
        build_program();
        while (halted !== 1'b1) begin
            run_cycle();
        end
        // retirement has to stay quiet once halted
        repeat (4) begin
            run_cycle();
        end
        assert (halt_retired) else begin
            error_count++;
            $display("halted is high but no halt was retired");
        end
        assert (exp_q.size() == 0) else begin
            error_count++;
            $display("%0d accepted instructions never retired", exp_q.size());
        end
        assert (retired_count == 32'(accepted_count))
            else report_value("retired_count", accepted_count, int'(retired_count));
        $display("errors: %0d, accepted: %0d, retired: %0d",
                 error_count, accepted_count, model_retired);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== design/ooo_core.sv ====
//////////////////////////////
// out-of-order core
//////////////////////////////
`timescale 1ns/10ps

module ooo_core #(
    parameter int N       = 2,
    parameter int DEPTH   = 16,
    parameter int MUL_LAT = 3
) (
    input  logic                                    clock,
    input  logic                                    reset,
    input  isa_pkg::fetch_packet   [N-1:0]          fetch,
    output logic                   [$clog2(N+1)-1:0] num_accept,
    output core_pkg::retire_packet [N-1:0]          retire,
    output logic                                    halted,
    output logic                   [31:0]           retired_count
);

    // dispatch side
    isa_pkg::decoded_packet   [N-1:0]           dec;
    core_pkg::phys_reg_idx    [N-1:0]           t;
    core_pkg::phys_reg_idx    [N-1:0]           t_old;
    logic                     [$clog2(N+1)-1:0] open_entries;
    // completion and retire side
    core_pkg::complete_packet [N-1:0]           alu_done;
    core_pkg::complete_packet [N-1:0]           mul_done;
    core_pkg::rob_packet      [N-1:0]           retiring_data;
    logic                     [$clog2(N+1)-1:0] num_retired;
    core_pkg::phys_reg_idx    [N-1:0]           release_t;
    logic                     [N-1:0]           release_valid;

    inst_decode #(.N(N)) i_inst_decode (
        .fetch (fetch),
        .dec   (dec)
    );

    rename_map #(.N(N)) i_rename_map (
        .clock         (clock),
        .reset         (reset),
        .dec           (dec),
        .open_entries  (open_entries),
        .release_t     (release_t),
        .release_valid (release_valid),
        .num_accept    (num_accept),
        .t             (t),
        .t_old         (t_old)
    );

    rob #(.N(N), .DEPTH(DEPTH)) i_rob (
        .clock         (clock),
        .reset         (reset),
        .wr_data       (dec),
        .t             (t),
        .t_old         (t_old),
        .num_accept    (num_accept),
        .alu_done      (alu_done),
        .mul_done      (mul_done),
        .retiring_data (retiring_data),
        .num_retired   (num_retired),
        .open_entries  (open_entries)
    );

    fu_pipes #(.N(N), .MUL_LAT(MUL_LAT)) i_fu_pipes (
        .clock      (clock),
        .reset      (reset),
        .dec        (dec),
        .t          (t),
        .num_accept (num_accept),
        .alu_done   (alu_done),
        .mul_done   (mul_done)
    );

    retire_unit #(.N(N)) i_retire_unit (
        .clock         (clock),
        .reset         (reset),
        .retiring_data (retiring_data),
        .num_retired   (num_retired),
        .retire        (retire),
        .release_t     (release_t),
        .release_valid (release_valid),
        .halted        (halted),
        .retired_count (retired_count)
    );

endmodule

// ==== design/retire_unit.sv ====
//////////////////////////////
// retire stage
//////////////////////////////
`timescale 1ns/10ps

module retire_unit #(
    parameter int N = 2
) (
    input  logic                                    clock,
    input  logic                                    reset,
    input  core_pkg::rob_packet    [N-1:0]          retiring_data,
    input  logic                   [$clog2(N+1)-1:0] num_retired,
    output core_pkg::retire_packet [N-1:0]          retire,
    output core_pkg::phys_reg_idx  [N-1:0]          release_t,
    output logic                   [N-1:0]          release_valid,
    output logic                                    halted,
    output logic                   [31:0]           retired_count
);

    localparam int CNT_W    = $clog2(N+1);
    localparam int NUM_ARCH = isa_pkg::NUM_ARCH_REGS;

    typedef enum logic {RUNNING, HALTED} retire_state_t;

    retire_state_t         state;
    retire_state_t         next_state;
    core_pkg::phys_reg_idx arch_map [NUM_ARCH];
    core_pkg::phys_reg_idx next_map [NUM_ARCH];
    logic [N-1:0]          t_old_ok;
    logic [CNT_W-1:0]      retire_cnt;
    logic                  halt_hit;

    always_comb begin
        next_map   = arch_map;
        next_state = state;
        retire_cnt = '0;
        halt_hit   = (state == HALTED);
        for (int i = 0; i < N; i++) begin
            // nothing after a halt, in this group or later
            retire[i].valid = !halt_hit && (CNT_W'(i) < num_retired) &&
                              retiring_data[i].valid;
            retire[i].pc    = retiring_data[i].pc;
            retire[i].dest  = retiring_data[i].dest;
            retire[i].halt  = retiring_data[i].halt;
            retire[i].t     = retiring_data[i].t;
            retire[i].t_old = retiring_data[i].t_old;

            release_t[i]     = retiring_data[i].t_old;
            release_valid[i] = retire[i].valid && !retiring_data[i].halt;

            // slot order, so a younger slot sees an older slot's update
            t_old_ok[i] = !release_valid[i] ||
                          next_map[retiring_data[i].dest] == retiring_data[i].t_old;
            if (release_valid[i]) begin
                next_map[retiring_data[i].dest] = retiring_data[i].t;
            end
            if (retire[i].valid) begin
                retire_cnt = retire_cnt + 1'b1;
                if (retiring_data[i].halt) begin
                    halt_hit   = 1'b1;
                    next_state = HALTED;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state         <= RUNNING;
            retired_count <= '0;
            for (int r = 0; r < NUM_ARCH; r++) begin
                arch_map[r] <= core_pkg::phys_reg_idx'(r);
            end
        end else begin
            state         <= next_state;
            retired_count <= retired_count + 32'(retire_cnt);
            arch_map      <= next_map;
        end
    end

    assign halted = (state == HALTED);

    assert property (@(posedge clock) disable iff (reset) num_retired <= CNT_W'(N))
        else $error("retire: %0d retired, width is %0d", num_retired, N);

    // speculative rename at dispatch has to agree with the committed map
    assert property (@(posedge clock) disable iff (reset) &t_old_ok)
        else $error("retire: t_old differs from the architectural map");

endmodule

// ==== design/fu_pipes.sv ====
//////////////////////////////
// execute lanes
//////////////////////////////
`timescale 1ns/10ps

module fu_pipes #(
    parameter int N       = 2,
    parameter int MUL_LAT = 3
) (
    input  logic                                      clock,
    input  logic                                      reset,
    input  isa_pkg::decoded_packet   [N-1:0]          dec,
    input  core_pkg::phys_reg_idx    [N-1:0]          t,
    input  logic                     [$clog2(N+1)-1:0] num_accept,
    output core_pkg::complete_packet [N-1:0]          alu_done,
    output core_pkg::complete_packet [N-1:0]          mul_done
);

    localparam int CNT_W = $clog2(N+1);

    // one alu stage and a MUL_LAT deep multiplier shift pipe per lane
    core_pkg::complete_packet [N-1:0]              alu_q;
    core_pkg::complete_packet [N-1:0][MUL_LAT-1:0] mul_q;
    logic [N-1:0] issue;

    // halts go to no unit
    always_comb begin
        for (int i = 0; i < N; i++) begin
            issue[i] = (CNT_W'(i) < num_accept) && !dec[i].halt;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < N; i++) begin
                alu_q[i].valid <= 1'b0;
                for (int s = 0; s < MUL_LAT; s++) begin
                    mul_q[i][s].valid <= 1'b0;
                end
            end
        end else begin
            for (int i = 0; i < N; i++) begin
                alu_q[i].valid    <= issue[i] && !dec[i].is_mul;
                alu_q[i].t        <= t[i];
                mul_q[i][0].valid <= issue[i] && dec[i].is_mul;
                mul_q[i][0].t     <= t[i];
                // several multiplies per lane can be in flight
                for (int s = 1; s < MUL_LAT; s++) begin
                    mul_q[i][s] <= mul_q[i][s-1];
                end
            end
        end
    end

    assign alu_done = alu_q;

    for (genvar g = 0; g < N; g++) begin : g_mul_out
        assign mul_done[g] = mul_q[g][MUL_LAT-1];
    end

endmodule

// ==== design/rob.sv ====
//////////////////////////////
// reorder buffer
//////////////////////////////
`timescale 1ns/10ps

// slot 0 of wr_data and retiring_data is the oldest
module rob #(
    parameter int N     = 2,
    parameter int DEPTH = 16
) (
    input  logic                                     clock,
    input  logic                                     reset,
    input  isa_pkg::decoded_packet  [N-1:0]          wr_data,
    input  core_pkg::phys_reg_idx   [N-1:0]          t,
    input  core_pkg::phys_reg_idx   [N-1:0]          t_old,
    input  logic                    [$clog2(N+1)-1:0] num_accept,
    input  core_pkg::complete_packet [N-1:0]         alu_done,
    input  core_pkg::complete_packet [N-1:0]         mul_done,
    output core_pkg::rob_packet     [N-1:0]          retiring_data,
    output logic                    [$clog2(N+1)-1:0] num_retired,
    output logic                    [$clog2(N+1)-1:0] open_entries
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CTR_W = PTR_W + 1;
    localparam int CNT_W = $clog2(N+1);

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W-1:0] next_head;
    logic [PTR_W-1:0] next_tail;
    logic [PTR_W-1:0] idx;
    logic [CTR_W-1:0] count;
    logic [CTR_W-1:0] next_count;
    logic [CTR_W-1:0] free_slots;
    logic             stop;

    core_pkg::rob_packet [DEPTH-1:0] entries;
    core_pkg::rob_packet [DEPTH-1:0] next_entries;

    // space after this cycle's retirement, capped at the dispatch width
    assign free_slots   = CTR_W'(DEPTH) - count + CTR_W'(num_retired);
    assign open_entries = (free_slots > CTR_W'(N)) ? CNT_W'(N) : CNT_W'(free_slots);

    always_comb begin
        next_entries  = entries;
        retiring_data = '0;
        num_retired   = '0;
        stop          = 1'b0;

        // retire first so the freed slots can take this cycle's group
        for (int i = 0; i < N; i++) begin
            idx = head + PTR_W'(i);
            if (!stop && entries[idx].valid && entries[idx].complete) begin
                retiring_data[i]         = entries[idx];
                next_entries[idx].valid  = 1'b0;
                num_retired              = num_retired + 1'b1;
            end else begin
                stop = 1'b1;
            end
        end
        next_head = head + PTR_W'(num_retired);

        // completion broadcast from both lane kinds
        for (int k = 0; k < DEPTH; k++) begin
            for (int j = 0; j < N; j++) begin
                if (entries[k].valid &&
                    ((alu_done[j].valid && alu_done[j].t == entries[k].t) ||
                     (mul_done[j].valid && mul_done[j].t == entries[k].t))) begin
                    next_entries[k].complete = 1'b1;
                end
            end
        end

        // new group at the tail, a halt has no unit and is born complete
        for (int j = 0; j < N; j++) begin
            if (CNT_W'(j) < num_accept) begin
                idx = tail + PTR_W'(j);
                next_entries[idx].valid    = 1'b1;
                next_entries[idx].complete = wr_data[j].halt;
                next_entries[idx].pc       = wr_data[j].pc;
                next_entries[idx].dest     = wr_data[j].dest;
                next_entries[idx].halt     = wr_data[j].halt;
                next_entries[idx].t        = t[j];
                next_entries[idx].t_old    = t_old[j];
            end
        end
        next_tail  = tail + PTR_W'(num_accept);
        next_count = count + CTR_W'(num_accept) - CTR_W'(num_retired);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int k = 0; k < DEPTH; k++) begin
                entries[k].valid <= 1'b0;
            end
        end else begin
            head    <= next_head;
            tail    <= next_tail;
            count   <= next_count;
            entries <= next_entries;
        end
    end

    // the rename stage must respect the space reported here
    assert property (@(posedge clock) disable iff (reset) num_accept <= open_entries)
        else $error("rob: accepted %0d with %0d open", num_accept, open_entries);

endmodule

// ==== design/rename_map.sv ====
//////////////////////////////
// rename and dispatch
//////////////////////////////
`timescale 1ns/10ps

module rename_map #(
    parameter int N = 2
) (
    input  logic                                  clock,
    input  logic                                  reset,
    input  isa_pkg::decoded_packet [N-1:0]        dec,
    input  logic                   [$clog2(N+1)-1:0] open_entries,
    input  core_pkg::phys_reg_idx  [N-1:0]        release_t,
    input  logic                   [N-1:0]        release_valid,
    output logic                   [$clog2(N+1)-1:0] num_accept,
    output core_pkg::phys_reg_idx  [N-1:0]        t,
    output core_pkg::phys_reg_idx  [N-1:0]        t_old
);

    localparam int CNT_W = $clog2(N+1);
    localparam int NUM_ARCH = isa_pkg::NUM_ARCH_REGS;
    localparam int NUM_PHYS = core_pkg::NUM_PHYS_REGS;

    typedef enum logic {DISPATCH, HALT_SEEN} dispatch_state_t;

    dispatch_state_t              state;
    dispatch_state_t              next_state;
    core_pkg::phys_reg_idx        map_table [NUM_ARCH];
    logic [NUM_PHYS-1:0]          free_list;
    logic [NUM_PHYS-1:0]          next_free;
    logic [NUM_PHYS-1:0]          avail;
    logic [$clog2(NUM_PHYS+1)-1:0] free_count;
    logic [CNT_W-1:0]             valid_count;
    logic [CNT_W-1:0]             halt_limit;
    logic [N-1:0]                 found;
    logic [N-1:0]                 alloc_mapped;

    // accept count, min of valid run, rob space, free tags and halt position
    always_comb begin
        free_count = '0;
        for (int p = 0; p < NUM_PHYS; p++) begin
            if (free_list[p]) begin
                free_count = free_count + 1'b1;
            end
        end
        valid_count = '0;
        halt_limit  = CNT_W'(N);
        for (int i = N - 1; i >= 0; i--) begin
            if (dec[i].valid && dec[i].halt) begin
                halt_limit = CNT_W'(i + 1);
            end
        end
        for (int i = 0; i < N; i++) begin
            if (dec[i].valid) begin
                valid_count = CNT_W'(i + 1);
            end
        end
        num_accept = valid_count;
        if (open_entries < num_accept) begin
            num_accept = open_entries;
        end
        if (halt_limit < num_accept) begin
            num_accept = halt_limit;
        end
        if (free_count < num_accept) begin
            num_accept = CNT_W'(free_count);
        end
        // nothing past a halt, and nothing while the core is in reset
        if (reset || state == HALT_SEEN) begin
            num_accept = '0;
        end
    end

    // lowest free tags in slot order, halts take none
    always_comb begin
        avail = free_list;
        for (int i = 0; i < N; i++) begin
            t[i]     = '0;
            found[i] = 1'b0;
            if (!dec[i].halt) begin
                for (int p = 0; p < NUM_PHYS; p++) begin
                    if (!found[i] && avail[p]) begin
                        t[i]     = core_pkg::phys_reg_idx'(p);
                        found[i] = 1'b1;
                    end
                end
                if (found[i]) begin
                    avail[t[i]] = 1'b0;
                end
            end
            t_old[i] = dec[i].halt ? '0 : map_table[dec[i].dest];
            // an older slot in the same group renamed this dest first
            for (int j = 0; j < i; j++) begin
                if (!dec[j].halt && !dec[i].halt && dec[j].dest == dec[i].dest) begin
                    t_old[i] = t[j];
                end
            end
        end
    end

    // a picked tag that the speculative map still holds is busy
    always_comb begin
        for (int i = 0; i < N; i++) begin
            alloc_mapped[i] = 1'b0;
            for (int r = 0; r < NUM_ARCH; r++) begin
                if (map_table[r] == t[i]) begin
                    alloc_mapped[i] = 1'b1;
                end
            end
        end
    end

    always_comb begin
        next_free  = free_list;
        next_state = state;
        // retired tags come back first, they never overlap with this cycle's picks
        for (int i = 0; i < N; i++) begin
            if (release_valid[i]) begin
                next_free[release_t[i]] = 1'b1;
            end
        end
        for (int i = 0; i < N; i++) begin
            if (CNT_W'(i) < num_accept) begin
                if (dec[i].halt) begin
                    next_state = HALT_SEEN;
                end else begin
                    next_free[t[i]] = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= DISPATCH;
            // identity map, upper half of the tags free
            for (int r = 0; r < NUM_ARCH; r++) begin
                map_table[r] <= core_pkg::phys_reg_idx'(r);
            end
            free_list <= {{(NUM_PHYS - NUM_ARCH){1'b1}}, {NUM_ARCH{1'b0}}};
        end else begin
            state     <= next_state;
            free_list <= next_free;
            // later slots win on the same dest
            for (int i = 0; i < N; i++) begin
                if (CNT_W'(i) < num_accept && !dec[i].halt) begin
                    map_table[dec[i].dest] <= t[i];
                end
            end
        end
    end

    for (genvar g = 0; g < N; g++) begin : g_alloc_chk
        assert property (@(posedge clock) disable iff (reset)
            (g < num_accept && !dec[g].halt) |-> !alloc_mapped[g])
            else $error("rename: slot %0d took tag %0d still in the map", g, t[g]);
    end

endmodule

// ==== design/inst_decode.sv ====
//////////////////////////////
// instruction decode
//////////////////////////////
`timescale 1ns/10ps

module inst_decode #(
    parameter int N = 2
) (
    input  isa_pkg::fetch_packet   [N-1:0] fetch,
    output isa_pkg::decoded_packet [N-1:0] dec
);

    // valid run from slot 0, drops at the first empty slot
    logic [N:0] run;

    always_comb begin
        run[0] = 1'b1;
        for (int i = 0; i < N; i++) begin
            run[i+1] = run[i] & fetch[i].valid;

            dec[i].valid  = run[i+1];
            dec[i].pc     = fetch[i].pc;
            dec[i].dest   = fetch[i].inst.dest;
            dec[i].is_mul = 1'b0;
            dec[i].halt   = 1'b0;

            case (fetch[i].inst.opcode)
                isa_pkg::OP_MUL: begin
                    dec[i].is_mul = 1'b1;
                end
                isa_pkg::OP_HALT: begin
                    dec[i].halt = 1'b1;
                end
                // add, sub, nop and unknown codes all go to the alu
                default: begin
                    dec[i].is_mul = 1'b0;
                end
            endcase
        end
    end

endmodule

// ==== design/core_pkg.sv ====
//////////////////////////////
// back end tag types
//////////////////////////////
package core_pkg;

    // physical register file size, twice the arch file
    localparam int NUM_PHYS_REGS = 64;

    typedef logic [5:0] phys_reg_idx;

    // one ROB slot
    typedef struct packed {
        logic                 valid;
        logic                 complete;
        isa_pkg::pc_t         pc;
        isa_pkg::arch_reg_idx dest;
        logic                 halt;
        phys_reg_idx          t;
        phys_reg_idx          t_old;
    } rob_packet;

    // completion broadcast from a functional unit lane
    typedef struct packed {
        logic        valid;
        phys_reg_idx t;
    } complete_packet;

    // retired instruction as seen outside the core
    typedef struct packed {
        logic                 valid;
        isa_pkg::pc_t         pc;
        isa_pkg::arch_reg_idx dest;
        logic                 halt;
        phys_reg_idx          t;
        phys_reg_idx          t_old;
    } retire_packet;

endpackage

// ==== design/isa_pkg.sv ====
//////////////////////////////
// instruction set types
//////////////////////////////
package isa_pkg;

    // architectural register file size
    localparam int NUM_ARCH_REGS = 32;

    typedef logic [4:0]  arch_reg_idx;
    typedef logic [15:0] pc_t;

    // codes 5 to 7 are unused and decode as a nop
    typedef enum logic [2:0] {
        OP_NOP  = 3'd0,
        OP_ADD  = 3'd1,
        OP_SUB  = 3'd2,
        OP_MUL  = 3'd3,
        OP_HALT = 3'd4
    } opcode_t;

    // 16-bit instruction, opcode in the top bits
    typedef struct packed {
        opcode_t     opcode;
        arch_reg_idx dest;
        logic [7:0]  imm;
    } inst_word;

    // one fetch slot, 33 bits
    typedef struct packed {
        logic     valid;
        pc_t      pc;
        inst_word inst;
    } fetch_packet;

    // decoder output, one per dispatch slot
    typedef struct packed {
        logic        valid;
        pc_t         pc;
        arch_reg_idx dest;
        logic        is_mul;
        logic        halt;
    } decoded_packet;

endpackage
